// ==== src/riscvPkg.sv ====
package riscvPkg;

	localparam int pcWidth = 12;
	localparam int dmemAddrWidth = 12;

	// ra value that marks the end of a program
	localparam logic [31:0] haltReturnAddr = 32'h0000_000C;

	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opReg = 7'b0110011;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluPassB
	} aluOpT;

	typedef enum logic [2:0] {
		stFetch, stDecode, stExecute, stMemAccess, stWriteBack, stHalted
	} fsmStateT;

	typedef enum logic [1:0] {aSelPc, aSelRegA, aSelZero} aluASelT;
	typedef enum logic [1:0] {bSelRegB, bSelImm, bSelFour} aluBSelT;
	typedef enum logic [1:0] {wbAluOut, wbMemData, wbPcLink} wbSelT;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sTypeT;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bTypeT;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} uTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		sTypeT sType;
		bTypeT bType;
		uTypeT uType;
	} instrWord;

endpackage

// ==== src/ctrlIf.sv ====
`timescale 1ns/1ps

interface ctrlIf;
	import riscvPkg::*;

	logic irWrite;
	logic pcWrite;
	// pc written only when the branch resolves taken
	logic pcCond;
	logic pcFromAluOut;
	aluASelT aluASel;
	aluBSelT aluBSel;
	aluOpT aluOp;
	wbSelT wbSel;
	logic regWrite;
	logic memWrite;
	logic memAccess;

	modport ctrl (
		output irWrite, pcWrite, pcCond, pcFromAluOut,
		output aluASel, aluBSel, aluOp,
		output wbSel, regWrite, memWrite, memAccess
	);

	modport dp (
		input irWrite, pcWrite, pcCond, pcFromAluOut,
		input aluASel, aluBSel, aluOp,
		input wbSel, regWrite, memWrite, memAccess
	);

endinterface

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
	input logic [31:0] a,
	input logic [31:0] b,
	input riscvPkg::aluOpT op,
	output logic [31:0] result,
	output logic zero
);
	import riscvPkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluSlt: result = {31'd0, $signed(a) < $signed(b)};
			aluSltu: result = {31'd0, a < b};
			aluSll: result = a << shamt;
			aluSrl: result = a >> shamt;
			aluSra: result = $unsigned($signed(a) >>> shamt);
			default: result = b;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

// ==== src/immGen.sv ====
`timescale 1ns/1ps

module immGen (
	input riscvPkg::instrWord instr,
	output logic [31:0] imm
);
	import riscvPkg::*;

	always_comb begin
		case (instr.rType.opcode)
			opStore: imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
			opBranch: imm = {{20{instr.bType.imm12}}, instr.bType.imm11,
				instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
			// J layout is scrambled inside the upper 20 bits
			opJal: imm = {{12{instr.uType.imm[19]}}, instr.uType.imm[7:0],
				instr.uType.imm[8], instr.uType.imm[18:9], 1'b0};
			opLui: imm = {instr.uType.imm, 12'd0};
			default: imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
		endcase
	end

endmodule

// ==== src/controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm (
	input logic CLK,
	input logic rstN,
	ctrlIf.ctrl ctrl,
	input riscvPkg::instrWord instr,
	input logic [31:0] rfRd1,
	input logic branchTaken,
	output logic iMemCsN,
	output logic halt,
	output logic [31:0] numInst
);
	import riscvPkg::*;

	fsmStateT state;
	fsmStateT nextState;
	logic [6:0] opcode;
	logic isHaltJalr;
	logic isHalt;
	logic lastCycle;
	aluOpT funcOp;

	assign opcode = instr.rType.opcode;

	// jalr x0, 0(ra)
	assign isHaltJalr = (opcode == opJalr) && (instr.iType.rd == 5'd0) &&
		(instr.iType.rs1 == 5'd1) && (instr.iType.imm == 12'd0) &&
		(instr.iType.funct3 == 3'b000);
	assign isHalt = isHaltJalr && (rfRd1 == haltReturnAddr);

	// funct3 and funct7 to ALU op for register and immediate forms
	always_comb begin
		case (instr.rType.funct3)
			3'b000: funcOp = (opcode == opReg && instr.rType.funct7[5]) ? aluSub : aluAdd;
			3'b001: funcOp = aluSll;
			3'b010: funcOp = aluSlt;
			3'b011: funcOp = aluSltu;
			3'b100: funcOp = aluXor;
			3'b101: funcOp = instr.rType.funct7[5] ? aluSra : aluSrl;
			3'b110: funcOp = aluOr;
			default: funcOp = aluAnd;
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			stFetch: nextState = stDecode;
			stDecode: nextState = isHalt ? stHalted : stExecute;
			stExecute: begin
				if (opcode == opBranch)
					nextState = stFetch;
				else if (opcode == opLoad || opcode == opStore)
					nextState = stMemAccess;
				else
					nextState = stWriteBack;
			end
			stMemAccess: nextState = (opcode == opLoad) ? stWriteBack : stFetch;
			stWriteBack: nextState = stFetch;
			default: nextState = stHalted;
		endcase
	end

	always_comb begin
		// default ALU work is pc + 4
		ctrl.irWrite = 1'b0;
		ctrl.pcWrite = 1'b0;
		ctrl.pcCond = 1'b0;
		ctrl.pcFromAluOut = 1'b0;
		ctrl.aluASel = aSelPc;
		ctrl.aluBSel = bSelFour;
		ctrl.aluOp = aluAdd;
		ctrl.wbSel = wbAluOut;
		ctrl.regWrite = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memAccess = 1'b0;
		case (state)
			stFetch: ctrl.irWrite = 1'b1;
			stDecode: begin
				// aluOut holds pc + 4 while the ALU forms the pc-relative target
				ctrl.pcWrite = (opcode != opJal);
				ctrl.pcFromAluOut = 1'b1;
				ctrl.aluBSel = bSelImm;
			end
			stExecute: begin
				case (opcode)
					opReg: begin
						ctrl.aluASel = aSelRegA;
						ctrl.aluBSel = bSelRegB;
						ctrl.aluOp = funcOp;
					end
					opImm: begin
						ctrl.aluASel = aSelRegA;
						ctrl.aluBSel = bSelImm;
						ctrl.aluOp = funcOp;
					end
					opLui: begin
						ctrl.aluASel = aSelZero;
						ctrl.aluBSel = bSelImm;
						ctrl.aluOp = aluPassB;
					end
					opBranch: begin
						ctrl.pcCond = 1'b1;
						ctrl.pcFromAluOut = 1'b1;
						ctrl.aluASel = aSelRegA;
						ctrl.aluBSel = bSelRegB;
						ctrl.aluOp = instr.bType.funct3[2] ? aluSlt : aluSub;
					end
					opJal: begin
						// jump now while the link value lands in aluOut
						ctrl.pcWrite = 1'b1;
						ctrl.pcFromAluOut = 1'b1;
					end
					default: begin
						ctrl.aluASel = aSelRegA;
						ctrl.aluBSel = bSelImm;
					end
				endcase
			end
			stMemAccess: begin
				ctrl.memAccess = 1'b1;
				ctrl.memWrite = (opcode == opStore);
			end
			stWriteBack: begin
				ctrl.regWrite = 1'b1;
				if (opcode == opLoad)
					ctrl.wbSel = wbMemData;
				else if (opcode == opJalr) begin
					ctrl.wbSel = wbPcLink;
					ctrl.pcWrite = 1'b1;
					ctrl.pcFromAluOut = 1'b1;
				end
			end
			default: ;
		endcase
	end

	assign lastCycle = (state == stWriteBack) ||
		(state == stExecute && opcode == opBranch) ||
		(state == stMemAccess && opcode == opStore);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= stFetch;
			numInst <= 32'd0;
		end else begin
			state <= nextState;
			if (lastCycle)
				numInst <= numInst + 32'd1;
		end
	end

	assign iMemCsN = (state != stFetch);
	assign halt = (state == stHalted);

	haltSticky: assert property (@(posedge CLK) disable iff (!rstN)
		state == stHalted |=> state == stHalted);
	noWriteConflict: assert property (@(posedge CLK) disable iff (!rstN)
		!(ctrl.regWrite && ctrl.memWrite));

endmodule

// ==== src/datapath.sv ====
`timescale 1ns/1ps

module datapath (
	input logic CLK,
	input logic rstN,
	ctrlIf.dp dp,
	input logic [31:0] iMemData,
	output logic [riscvPkg::pcWidth-1:0] iMemAddr,
	output logic dMemCsN,
	output logic dMemWen,
	output logic [riscvPkg::dmemAddrWidth-1:0] dMemAddr,
	output logic [31:0] dMemWdata,
	input logic [31:0] dMemRdata,
	output logic [4:0] rfRa1,
	output logic [4:0] rfRa2,
	output logic [4:0] rfWa,
	output logic [31:0] rfWd,
	output logic rfWe,
	input logic [31:0] rfRd1,
	input logic [31:0] rfRd2,
	output riscvPkg::instrWord instr,
	output logic branchTaken,
	output logic [31:0] outputPort
);
	import riscvPkg::*;

	logic [pcWidth-1:0] pc;
	logic [pcWidth-1:0] pcSrc;
	logic [31:0] pcExt;
	logic [31:0] regA;
	logic [31:0] regB;
	logic [31:0] aluOut;
	logic [31:0] memData;
	logic [31:0] imm;
	logic [31:0] aluA;
	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic aluZero;
	logic condMet;

	assign pcExt = {{(32 - pcWidth){1'b0}}, pc};
	assign pcSrc = dp.pcFromAluOut ? aluOut[pcWidth-1:0] : aluResult[pcWidth-1:0];

	// bit 0 cleared for jalr targets
	always_ff @(posedge CLK) begin
		if (!rstN)
			pc <= '0;
		else if (dp.pcWrite || branchTaken)
			pc <= {pcSrc[pcWidth-1:1], 1'b0};
	end

	always_ff @(posedge CLK) begin
		if (dp.irWrite)
			instr <= iMemData;
		regA <= rfRd1;
		regB <= rfRd2;
		aluOut <= aluResult;
		memData <= dMemRdata;
	end

	immGen immGen_inst (
		.instr(instr),
		.imm(imm)
	);

	always_comb begin
		case (dp.aluASel)
			aSelPc: aluA = pcExt;
			aSelRegA: aluA = regA;
			default: aluA = 32'd0;
		endcase
		case (dp.aluBSel)
			bSelRegB: aluB = regB;
			bSelImm: aluB = imm;
			default: aluB = 32'd4;
		endcase
	end

	alu alu_inst (
		.a(aluA),
		.b(aluB),
		.op(dp.aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	// beq/bne on zero, blt/bge on slt, funct3[0] inverts
	assign condMet = instr.bType.funct3[2] ? aluResult[0] : aluZero;
	assign branchTaken = dp.pcCond && (condMet ^ instr.bType.funct3[0]);

	always_comb begin
		case (dp.wbSel)
			wbMemData: rfWd = memData;
			wbPcLink: rfWd = pcExt;
			default: rfWd = aluOut;
		endcase
	end

	assign iMemAddr = pc;
	assign rfRa1 = instr.rType.rs1;
	assign rfRa2 = instr.rType.rs2;
	assign rfWa = instr.rType.rd;
	assign rfWe = dp.regWrite;

	assign dMemCsN = !dp.memAccess;
	assign dMemWen = !dp.memWrite;
	assign dMemAddr = aluOut[dmemAddrWidth+1:2];
	assign dMemWdata = regB;

	always_ff @(posedge CLK) begin
		if (!rstN)
			outputPort <= 32'd0;
		else if (rfWe)
			outputPort <= rfWd;
	end

	pcAligned: assert property (@(posedge CLK) disable iff (!rstN)
		iMemAddr[1:0] == 2'b00);

endmodule

// ==== src/riscvTop.sv ====
`timescale 1ns/1ps

module riscvTop (
	input logic CLK,
	input logic rstN,
	output logic iMemCsN,
	output logic [riscvPkg::pcWidth-1:0] iMemAddr,
	input logic [31:0] iMemData,
	output logic dMemCsN,
	output logic [riscvPkg::dmemAddrWidth-1:0] dMemAddr,
	output logic dMemWen,
	output logic [31:0] dMemWdata,
	input logic [31:0] dMemRdata,
	output logic rfWe,
	output logic [4:0] rfRa1,
	output logic [4:0] rfRa2,
	output logic [4:0] rfWa,
	output logic [31:0] rfWd,
	input logic [31:0] rfRd1,
	input logic [31:0] rfRd2,
	output logic halt,
	output logic [31:0] numInst,
	output logic [31:0] outputPort
);
	import riscvPkg::*;

	instrWord instr;
	logic branchTaken;

	ctrlIf ctrlBus ();

	controlFsm controlFsm_inst (
		.CLK(CLK),
		.rstN(rstN),
		.ctrl(ctrlBus.ctrl),
		.instr(instr),
		.rfRd1(rfRd1),
		.branchTaken(branchTaken),
		.iMemCsN(iMemCsN),
		.halt(halt),
		.numInst(numInst)
	);

	datapath datapath_inst (
		.CLK(CLK),
		.rstN(rstN),
		.dp(ctrlBus.dp),
		.iMemData(iMemData),
		.iMemAddr(iMemAddr),
		.dMemCsN(dMemCsN),
		.dMemWen(dMemWen),
		.dMemAddr(dMemAddr),
		.dMemWdata(dMemWdata),
		.dMemRdata(dMemRdata),
		.rfRa1(rfRa1),
		.rfRa2(rfRa2),
		.rfWa(rfWa),
		.rfWd(rfWd),
		.rfWe(rfWe),
		.rfRd1(rfRd1),
		.rfRd2(rfRd2),
		.instr(instr),
		.branchTaken(branchTaken),
		.outputPort(outputPort)
	);

endmodule

// ==== sim/tbRiscvTop.sv ====
`timescale 1ns/1ps

module tbRiscvTop;
	import riscvPkg::*;

	logic CLK;
	logic rstN;
	logic iMemCsN;
	logic [pcWidth-1:0] iMemAddr;
	logic [31:0] iMemData;
	logic dMemCsN;
	logic [dmemAddrWidth-1:0] dMemAddr;
	logic dMemWen;
	logic [31:0] dMemWdata;
	logic [31:0] dMemRdata;
	logic rfWe;
	logic [4:0] rfRa1;
	logic [4:0] rfRa2;
	logic [4:0] rfWa;
	logic [31:0] rfWd;
	logic [31:0] rfRd1;
	logic [31:0] rfRd2;
	logic halt;
	logic [31:0] numInst;
	logic [31:0] outputPort;

	logic [31:0] imem [0:1023];
	logic [31:0] dmem [0:1023];
	logic [31:0] rf [0:31];
	// reference model state
	logic [31:0] mRf [0:31];
	logic [31:0] mDmem [0:1023];
	logic [36:0] expWrites [$];
	int expRetired;
	logic running;
	logic [31:0] expOut;
	logic [36:0] writeEntry;

	riscvTop riscvTop_inst (
		.CLK(CLK),
		.rstN(rstN),
		.iMemCsN(iMemCsN),
		.iMemAddr(iMemAddr),
		.iMemData(iMemData),
		.dMemCsN(dMemCsN),
		.dMemAddr(dMemAddr),
		.dMemWen(dMemWen),
		.dMemWdata(dMemWdata),
		.dMemRdata(dMemRdata),
		.rfWe(rfWe),
		.rfRa1(rfRa1),
		.rfRa2(rfRa2),
		.rfWa(rfWa),
		.rfWd(rfWd),
		.rfRd1(rfRd1),
		.rfRd2(rfRd2),
		.halt(halt),
		.numInst(numInst),
		.outputPort(outputPort)
	);

	always #5 CLK = ~CLK;

	// memories and register file read combinationally
	assign iMemData = imem[iMemAddr[pcWidth-1:2]];
	assign dMemRdata = dmem[dMemAddr[9:0]];
	assign rfRd1 = rf[rfRa1];
	assign rfRd2 = rf[rfRa2];

	always @(posedge CLK) begin
		if (rfWe && rfWa != 5'd0)
			rf[rfWa] <= rfWd;
		if (!dMemCsN && !dMemWen)
			dmem[dMemAddr[9:0]] <= dMemWdata;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			failRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, actual,
				expected));
	endtask

	function automatic logic [31:0] referenceAlu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << sh;
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// forward-only control flow that ends with the ra load and the halt jalr
	task automatic writeProgram(output int progLen);
		int bodyLen;
		int i;
		int kind;
		int target;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm12;
		logic [19:0] imm20;
		logic [12:0] offB;
		logic [20:0] offJ;
		bodyLen = 62 + ($urandom % 57);
		progLen = bodyLen + 2;
		// nop fill carrying its own word address
		for (i = 0; i < 1024; i++)
			imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, opImm};
		for (i = 0; i < bodyLen; i++) begin
			kind = $urandom % 16;
			rd = $urandom;
			rs1 = $urandom;
			rs2 = ($urandom % 4 == 0) ? rs1 : 5'($urandom);
			f3 = $urandom;
			imm12 = $urandom;
			imm20 = $urandom;
			target = i + 1 + ($urandom % 3);
			if (target > bodyLen)
				target = bodyLen;
			case (kind)
				0, 1, 2, 3, 4: begin
					f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ? 7'h20 : 7'h00;
					imem[i] = {f7, rs2, rs1, f3, rd, opReg};
				end
				5, 6, 7: begin
					if (f3 == 3'd1)
						imm12[11:5] = 7'h00;
					else if (f3 == 3'd5)
						imm12[11:5] = imm12[10] ? 7'h20 : 7'h00;
					imem[i] = {imm12, rs1, f3, rd, opImm};
				end
				8: imem[i] = {imm20, rd, opLui};
				9, 15: begin
					imm12 = ($urandom % 64) * 4;
					imem[i] = {imm12, 5'd0, 3'b010, rd, opLoad};
				end
				10: begin
					imm12 = ($urandom % 64) * 4;
					imem[i] = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], opStore};
				end
				11, 12: begin
					f3 = {f3[2], 1'b0, f3[0]};
					offB = (target - i) * 4;
					imem[i] = {offB[12], offB[10:5], rs2, rs1, f3, offB[4:1], offB[11], opBranch};
				end
				13: begin
					offJ = (target - i) * 4;
					imem[i] = {offJ[20], offJ[10:1], offJ[11], offJ[19:12], rd, opJal};
				end
				default: begin
					imm12 = target * 4;
					imem[i] = {imm12, 5'd0, 3'b000, rd, opJalr};
				end
			endcase
		end
		imem[bodyLen] = {haltReturnAddr[11:0], 5'd0, 3'b000, 5'd1, opImm};
		imem[bodyLen + 1] = {12'd0, 5'd1, 3'b000, 5'd0, opJalr};
	endtask

	// ISA-level execution of the loaded program
	task automatic runIsaModel(input int progLen);
		logic [31:0] pc;
		logic [31:0] pcNext;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		logic [31:0] addr;
		logic [31:0] immI;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [6:0] op;
		logic [4:0] rd;
		logic [2:0] f3;
		logic taken;
		logic wr;
		logic done;
		int steps;
		pc = 32'd0;
		done = 1'b0;
		steps = 0;
		expRetired = 0;
		expWrites.delete();
		while (!done && steps <= progLen) begin
			w = imem[pc[11:2]];
			op = w[6:0];
			rd = w[11:7];
			f3 = w[14:12];
			a = mRf[w[19:15]];
			b = mRf[w[24:20]];
			immI = {{20{w[31]}}, w[31:20]};
			immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			if (op == opJalr && immI == 32'd0 && w[19:15] == 5'd1 && f3 == 3'd0 &&
				rd == 5'd0 && a == haltReturnAddr) begin
				done = 1'b1;
			end else begin
				pcNext = pc + 32'd4;
				val = pc + 32'd4;
				wr = 1'b1;
				case (op)
					opReg: val = referenceAlu(f3, w[30], a, b);
					opImm: val = referenceAlu(f3, w[30] && f3 == 3'd5, a, immI);
					opLui: val = {w[31:12], 12'd0};
					opLoad: begin
						addr = a + immI;
						val = mDmem[addr[11:2]];
					end
					opStore: begin
						addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
						mDmem[addr[11:2]] = b;
						wr = 1'b0;
					end
					opBranch: begin
						wr = 1'b0;
						case (f3)
							3'd0: taken = (a == b);
							3'd1: taken = (a != b);
							3'd4: taken = ($signed(a) < $signed(b));
							default: taken = !($signed(a) < $signed(b));
						endcase
						if (taken)
							pcNext = pc + immB;
					end
					opJal: pcNext = pc + immJ;
					opJalr: pcNext = (a + immI) & ~32'd1;
					default: failRun("reference model met an unsupported opcode");
				endcase
				if (wr) begin
					expWrites.push_back({rd, val});
					if (rd != 5'd0)
						mRf[rd] = val;
				end
				expRetired++;
				pc = pcNext;
				steps++;
			end
		end
		if (!done)
			failRun("reference model did not reach the halt instruction");
	endtask

	task automatic runTest(input int testIdx);
		int progLen;
		int cycles;
		int limit;
		int r;
		@(posedge CLK);
		rstN <= 1'b0;
		running = 1'b0;
		for (r = 0; r < 32; r++) begin
			mRf[r] = (r == 0) ? 32'd0 : (($urandom % 2) ? $urandom : $urandom % 16);
			rf[r] <= mRf[r];
		end
		for (r = 0; r < 1024; r++) begin
			mDmem[r] = $urandom;
			dmem[r] <= mDmem[r];
		end
		writeProgram(progLen);
		runIsaModel(progLen);
		repeat (8) @(posedge CLK);
		rstN <= 1'b1;
		running = 1'b1;
		@(negedge CLK);
		compareValue("halt", {31'd0, halt}, 32'd0);
		compareValue("rfWe", {31'd0, rfWe}, 32'd0);
		compareValue("numInst", numInst, 32'd0);
		compareValue("dMemCsN", {31'd0, dMemCsN}, 32'd1);
		cycles = 0;
		limit = 5 * progLen + 100;
		while (!halt && cycles < limit) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halt) begin
			failRun($sformatf("core never halted within %0d cycles in test %0d", limit, testIdx));
		end else begin
			// halt must hold with no further fetch
			repeat (10) begin
				@(negedge CLK);
				compareValue("halt", {31'd0, halt}, 32'd1);
			end
			compareValue("numInst", numInst, expRetired);
			compareValue("pending writes", expWrites.size(), 32'd0);
			for (r = 0; r < 32; r++)
				compareValue($sformatf("x%0d", r), rf[r], mRf[r]);
			for (r = 0; r < 1024; r++)
				compareValue($sformatf("dmem[%0d]", r), dmem[r], mDmem[r]);
		end
	endtask

	always @(negedge CLK) begin
		if (!running) begin
			expOut = 32'd0;
		end else begin
			compareValue("outputPort", outputPort, expOut);
			if (rfWe) begin
				if (expWrites.size() == 0) begin
					failRun("core wrote a register after the expected write sequence ended");
				end else begin
					writeEntry = expWrites.pop_front();
					compareValue("rfWa", {27'd0, rfWa}, {27'd0, writeEntry[36:32]});
					compareValue("rfWd", rfWd, writeEntry[31:0]);
					expOut = writeEntry[31:0];
				end
			end
			if (halt && !iMemCsN)
				failRun("instruction fetch seen after halt");
		end
	end

	initial begin
		int t;
		CLK = 1'b0;
		rstN = 1'b0;
		running = 1'b0;
		expOut = 32'd0;
		for (t = 0; t < 1024; t++) begin
			imem[t] = {12'(t), 5'd0, 3'b000, 5'd0, opImm};
			dmem[t] <= t;
		end
		for (t = 0; t < 32; t++)
			rf[t] <= 32'd0;
		void'($urandom(96));
		for (t = 0; t < 5; t++)
			runTest(t);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== compile.f ====
src/riscvPkg.sv
src/ctrlIf.sv
src/alu.sv
src/immGen.sv
src/controlFsm.sv
src/datapath.sv
src/riscvTop.sv
sim/tbRiscvTop.sv
